// File: rtl/rvv_dispatch_pkg.sv
/*
 * shared sizes and uop views for the rvv dispatch RAW hazard logic
 * imported by every dispatch module; the testbench uses the same types
 */
`default_nettype none

package rvv_dispatch_pkg;

    // register file shape
    localparam int vreg_num   = 32;
    localparam int vreg_idx_w = $clog2(vreg_num); // 5 bits
    localparam logic [vreg_idx_w-1:0] v0_index = '0; // mask register

    // dispatch shape
    localparam int dispatch_width = 2; // head slots looked at per cycle
    localparam int exe_depth      = 3; // bypass only from the last stage

    // one entry at the head of the uop queue
    typedef struct packed {
        logic                  valid;
        logic [vreg_idx_w-1:0] vs1_index;
        logic                  vs1_valid;
        logic [vreg_idx_w-1:0] vs2_index;
        logic                  vs2_valid;
        logic [vreg_idx_w-1:0] vd_index;
        logic                  vs3_valid; // vd also read (store, madd)
        logic                  vm;        // 0 -> v0 read as mask
        logic                  vd_we;     // uop writes vd
    } dispatch_uop_t;

    // sources of a successor uop
    typedef struct packed {
        logic [vreg_idx_w-1:0] vs1_index;
        logic                  vs1_valid;
        logic [vreg_idx_w-1:0] vs2_index;
        logic                  vs2_valid;
        logic [vreg_idx_w-1:0] vd_index;
        logic                  vs3_valid;
        logic                  vm;
    } suc_uop_raw_t;

    // destination of a predecessor uop
    typedef struct packed {
        logic                  valid;
        logic [vreg_idx_w-1:0] w_index;
        logic                  w_valid; // result ready for bypass
    } pre_uop_raw_t;

    // per source class wait flags
    typedef struct packed {
        logic vs1_wait;
        logic vs2_wait;
        logic vd_wait;
        logic v0_wait;
    } raw_uop_uop_t;

endpackage

`default_nettype wire

// File: rtl/rvv_dispatch_raw_uop_uop.sv
/*
 * RAW check of one successor uop against preuop_num predecessor writes
 * purely combinational, one wait bit per source class out
 */
`default_nettype none

module rvv_dispatch_raw_uop_uop #(
    parameter int preuop_num = 1
) (
    output rvv_dispatch_pkg::raw_uop_uop_t                  raw_uop_uop,
    input  rvv_dispatch_pkg::suc_uop_raw_t                  suc_uop,
    input  rvv_dispatch_pkg::pre_uop_raw_t [preuop_num-1:0] pre_uop
);

    import rvv_dispatch_pkg::*;

    logic [preuop_num-1:0] vs1_hit; // index match on a source that is read
    logic [preuop_num-1:0] vs2_hit;
    logic [preuop_num-1:0] vd_hit;
    logic [preuop_num-1:0] v0_hit;
    logic [preuop_num-1:0] pending; // write not yet bypassable

    genvar i;
    generate
        for (i = 0; i < preuop_num; i++) begin : gen_pre
            // only live writes that cannot be forwarded yet
            assign pending[i] = pre_uop[i].valid & ~pre_uop[i].w_valid;

            assign vs1_hit[i] = suc_uop.vs1_valid &
                                (suc_uop.vs1_index == pre_uop[i].w_index);
            assign vs2_hit[i] = suc_uop.vs2_valid &
                                (suc_uop.vs2_index == pre_uop[i].w_index);
            assign vd_hit[i]  = suc_uop.vs3_valid &
                                (suc_uop.vd_index == pre_uop[i].w_index);
            // masked op reads v0 implicitly
            assign v0_hit[i]  = ~suc_uop.vm & (v0_index == pre_uop[i].w_index);
        end
    endgenerate

    // any pending predecessor hit stalls that source
    assign raw_uop_uop.vs1_wait = |(vs1_hit & pending);
    assign raw_uop_uop.vs2_wait = |(vs2_hit & pending);
    assign raw_uop_uop.vd_wait  = |(vd_hit & pending);
    assign raw_uop_uop.v0_wait  = |(v0_hit & pending);

endmodule

`default_nettype wire

// File: rtl/rvv_dispatch_inflight.sv
/*
 * tracks vd writes of dispatched uops through the fixed execute pipeline
 * one shift lane per dispatch slot, last stage flagged as bypassable
 */
`default_nettype none

module rvv_dispatch_inflight (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  rvv_dispatch_pkg::pre_uop_raw_t
               [rvv_dispatch_pkg::dispatch_width-1:0]    issue,
    output rvv_dispatch_pkg::pre_uop_raw_t
               [rvv_dispatch_pkg::dispatch_width*rvv_dispatch_pkg::exe_depth-1:0] pre_uop
);

    import rvv_dispatch_pkg::*;

    // stage 0 here is execute stage 1
    logic [exe_depth-1:0][dispatch_width-1:0]                 stage_valid;
    logic [exe_depth-1:0][dispatch_width-1:0][vreg_idx_w-1:0] stage_index;

    // valid bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= '0; // pipe empty
        end else begin
            for (int l = 0; l < dispatch_width; l++) begin
                stage_valid[0][l] <= issue[l].valid;
            end
            for (int s = 1; s < exe_depth; s++) begin
                stage_valid[s] <= stage_valid[s-1]; // advance one stage
            end
        end
    end

    // write indices follow the valids
    always_ff @(posedge clk) begin
        for (int l = 0; l < dispatch_width; l++) begin
            stage_index[0][l] <= issue[l].w_index;
        end
        for (int s = 1; s < exe_depth; s++) begin
            stage_index[s] <= stage_index[s-1];
        end
    end

    // flatten stage by stage, lane inside stage
    always_comb begin
        for (int s = 0; s < exe_depth; s++) begin
            for (int l = 0; l < dispatch_width; l++) begin
                pre_uop[s*dispatch_width+l].valid   = stage_valid[s][l];
                pre_uop[s*dispatch_width+l].w_index = stage_index[s][l];
                // result forwarded from final stage
                pre_uop[s*dispatch_width+l].w_valid = (s == exe_depth - 1);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rvv_dispatch_ctrl.sv
/*
 * in-order dispatch decision for the two oldest queue uops
 * checks each slot against in-flight writes, slot 1 also against slot 0
 */
`default_nettype none

module rvv_dispatch_ctrl (
    input  rvv_dispatch_pkg::dispatch_uop_t
               [rvv_dispatch_pkg::dispatch_width-1:0]    uop,
    input  rvv_dispatch_pkg::pre_uop_raw_t
               [rvv_dispatch_pkg::dispatch_width*rvv_dispatch_pkg::exe_depth-1:0] pre_uop,
    output logic [rvv_dispatch_pkg::dispatch_width-1:0]  ack,
    output rvv_dispatch_pkg::pre_uop_raw_t
               [rvv_dispatch_pkg::dispatch_width-1:0]    issue
);

    import rvv_dispatch_pkg::*;

    suc_uop_raw_t [dispatch_width-1:0] suc_uop; // source view per slot
    pre_uop_raw_t                      pair_pre; // slot 0 as writer for slot 1

    raw_uop_uop_t raw_slot0;   // slot 0 vs in flight
    raw_uop_uop_t raw_slot1;   // slot 1 vs in flight
    raw_uop_uop_t raw_pair;    // slot 1 vs slot 0

    // strip queue entries down to their sources
    always_comb begin
        for (int i = 0; i < dispatch_width; i++) begin
            suc_uop[i].vs1_index = uop[i].vs1_index;
            suc_uop[i].vs1_valid = uop[i].vs1_valid;
            suc_uop[i].vs2_index = uop[i].vs2_index;
            suc_uop[i].vs2_valid = uop[i].vs2_valid;
            suc_uop[i].vd_index  = uop[i].vd_index;
            suc_uop[i].vs3_valid = uop[i].vs3_valid;
            suc_uop[i].vm        = uop[i].vm;
        end
    end

    // slot 0 result is never ready in the same cycle
    assign pair_pre.valid   = uop[0].valid & uop[0].vd_we;
    assign pair_pre.w_index = uop[0].vd_index;
    assign pair_pre.w_valid = 1'b0;

    rvv_dispatch_raw_uop_uop #(
        .preuop_num (dispatch_width * exe_depth)
    ) u_raw_slot0 (
        .raw_uop_uop (raw_slot0),
        .suc_uop     (suc_uop[0]),
        .pre_uop     (pre_uop)
    );

    rvv_dispatch_raw_uop_uop #(
        .preuop_num (dispatch_width * exe_depth)
    ) u_raw_slot1 (
        .raw_uop_uop (raw_slot1),
        .suc_uop     (suc_uop[1]),
        .pre_uop     (pre_uop)
    );

    rvv_dispatch_raw_uop_uop #(
        .preuop_num (1)
    ) u_raw_pair (
        .raw_uop_uop (raw_pair),
        .suc_uop     (suc_uop[1]),
        .pre_uop     (pair_pre)
    );

    // strictly in order, slot 1 needs slot 0 to go
    assign ack[0] = uop[0].valid & ~(|raw_slot0);
    assign ack[1] = uop[1].valid & ack[0] & ~(|raw_slot1) & ~(|raw_pair);

    // only acked writers enter the tracker
    always_comb begin
        for (int i = 0; i < dispatch_width; i++) begin
            issue[i].valid   = ack[i] & uop[i].vd_we;
            issue[i].w_index = uop[i].vd_index;
            issue[i].w_valid = 1'b0; // fresh uop, nothing to forward
        end
    end

endmodule

`default_nettype wire

// File: rtl/rvv_dispatch.sv
/*
 * RAW hazard dispatch stage top, queue head in, ack strobes and issues out
 * ack and issue are combinational from uop and the in-flight state
 */
`default_nettype none

module rvv_dispatch (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  rvv_dispatch_pkg::dispatch_uop_t
               [rvv_dispatch_pkg::dispatch_width-1:0]    uop,
    output logic [rvv_dispatch_pkg::dispatch_width-1:0]  ack,
    output rvv_dispatch_pkg::pre_uop_raw_t
               [rvv_dispatch_pkg::dispatch_width-1:0]    issue
);

    import rvv_dispatch_pkg::*;

    // execute pipe writes seen by the hazard check
    pre_uop_raw_t [dispatch_width*exe_depth-1:0] pre_uop;

    rvv_dispatch_ctrl u_ctrl (
        .uop     (uop),
        .pre_uop (pre_uop),
        .ack     (ack),
        .issue   (issue)
    );

    rvv_dispatch_inflight u_inflight (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue   (issue),  // acked writers enter stage 1
        .pre_uop (pre_uop)
    );

endmodule

`default_nettype wire

// File: tests/tb_rvv_dispatch.sv
/*
 * random-stimulus testbench for the rvv dispatch RAW hazard stage
 * a 2000 entry uop queue feeds the two head slots, a model predicts ack and issue
 */
`default_nettype none

module tb_rvv_dispatch;

    timeunit 1ns;
    timeprecision 100ps;

    import rvv_dispatch_pkg::*;

    localparam int num_uops    = 2000;
    localparam int idle_cycles = 3; // no valid uop right after reset
    // a head uop stalls at most exe_depth-1 cycles, then goes on the next
    localparam int cycle_limit = 2 + idle_cycles + num_uops * exe_depth + 50;

    logic                               clk = 1'b0;
    logic                               arst_n;
    dispatch_uop_t [dispatch_width-1:0] uop;
    logic [dispatch_width-1:0]          ack;
    pre_uop_raw_t [dispatch_width-1:0]  issue;

    dispatch_uop_t queue_mem [num_uops]; // uop queue, popped from head
    int            head;
    logic [31:0]   rng;
    int            cycle_cnt = 0;

    // model copy of the execute pipe, stage 0 is execute stage 1
    logic                  m_valid [exe_depth][dispatch_width];
    logic [vreg_idx_w-1:0] m_index [exe_depth][dispatch_width];

    int stall_cycles; // head valid but held
    int pair_splits;  // slot 0 goes, slot 1 held
    int dual_acks;

    rvv_dispatch uut (
        .clk    (clk),
        .arst_n (arst_n),
        .uop    (uop),
        .ack    (ack),
        .issue  (issue)
    );

    always #2 clk = ~clk; // 4 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Some tests failed");
            $fatal(1, "timeout: queue not drained after %0d cycles", cycle_cnt);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // indices kept in v0..v7 so hazards are frequent
    function automatic dispatch_uop_t random_uop(input logic [31:0] r);
        dispatch_uop_t u;
        u.valid     = 1'b1;
        u.vs1_index = {2'b00, r[2:0]};
        u.vs1_valid = r[3];
        u.vs2_index = {2'b00, r[6:4]};
        u.vs2_valid = r[7];
        u.vd_index  = {2'b00, r[10:8]};
        u.vs3_valid = (r[13:11] == 3'd0); // stores and madd are rarer
        u.vm        = r[14] | r[15];      // one in four masked
        u.vd_we     = (r[17:16] != 2'd0);
        return u;
    endfunction

    // true when u reads register idx as a source
    function automatic logic reads_reg(input dispatch_uop_t u,
                                       input logic [vreg_idx_w-1:0] idx);
        logic hit;
        hit = 1'b0;
        if (u.vs1_valid && u.vs1_index == idx) hit = 1'b1;
        if (u.vs2_valid && u.vs2_index == idx) hit = 1'b1;
        if (u.vs3_valid && u.vd_index == idx) hit = 1'b1;
        if (!u.vm && idx == v0_index) hit = 1'b1; // mask read
        return hit;
    endfunction

    function automatic logic pipe_blocks(input dispatch_uop_t u);
        logic hit;
        hit = 1'b0;
        // last stage forwards, so it never blocks
        for (int s = 0; s < exe_depth - 1; s++) begin
            for (int l = 0; l < dispatch_width; l++) begin
                if (m_valid[s][l] && reads_reg(u, m_index[s][l])) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    function automatic dispatch_uop_t slot_entry(input int idx, input logic feed);
        if (!feed || idx >= num_uops) begin
            return '0; // empty slot
        end
        return queue_mem[idx];
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp,
                            input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // check mid-cycle, advance the model, pop and drive the next head on the edge
    task automatic run_cycle(input logic feed);
        logic [dispatch_width-1:0]         exp_ack;
        pre_uop_raw_t [dispatch_width-1:0] exp_issue;
        @(negedge clk); // outputs settled, pipe state stable
        exp_ack[0] = uop[0].valid && !pipe_blocks(uop[0]);
        exp_ack[1] = uop[1].valid && exp_ack[0] && !pipe_blocks(uop[1]) &&
                     !(uop[0].vd_we && reads_reg(uop[1], uop[0].vd_index));
        for (int i = 0; i < dispatch_width; i++) begin
            exp_issue[i].valid   = exp_ack[i] && uop[i].vd_we;
            exp_issue[i].w_index = uop[i].vd_index;
            exp_issue[i].w_valid = 1'b0;
        end

        check_eq(64'(ack), 64'(exp_ack), "ack");
        check_eq(64'(issue), 64'(exp_issue), "issue");

        if (uop[0].valid && !exp_ack[0]) stall_cycles++;
        if (uop[1].valid && exp_ack[0] && !exp_ack[1]) pair_splits++;
        if (exp_ack == 2'b11) dual_acks++;

        // model pipe moves one stage per edge
        for (int s = exe_depth - 1; s > 0; s--) begin
            for (int l = 0; l < dispatch_width; l++) begin
                m_valid[s][l] = m_valid[s-1][l];
                m_index[s][l] = m_index[s-1][l];
            end
        end
        for (int l = 0; l < dispatch_width; l++) begin
            m_valid[0][l] = exp_issue[l].valid;
            m_index[0][l] = exp_issue[l].w_index;
        end

        head = head + int'(exp_ack[0]) + int'(exp_ack[1]); // pop in order
        @(posedge clk);
        uop[0] <= slot_entry(head, feed);
        uop[1] <= slot_entry(head + 1, feed);
    endtask

    initial begin
        arst_n       = 1'b0;
        uop          = '0;
        rng          = 32'd21;
        head         = 0;
        stall_cycles = 0;
        pair_splits  = 0;
        dual_acks    = 0;
        for (int s = 0; s < exe_depth; s++) begin
            for (int l = 0; l < dispatch_width; l++) begin
                m_valid[s][l] = 1'b0;
                m_index[s][l] = '0;
            end
        end
        for (int i = 0; i < num_uops; i++) begin
            rng          = xorshift32(rng);
            queue_mem[i] = random_uop(rng);
        end

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // empty head after reset, nothing may be acked
        repeat (idle_cycles) begin
            run_cycle(1'b0);
        end
        while (head < num_uops) begin
            run_cycle(1'b1);
        end
        // let the pipe drain with empty slots
        repeat (exe_depth) begin
            run_cycle(1'b1);
        end

        check_eq(64'(stall_cycles > 0), 64'd1, "hazard stalls seen");
        check_eq(64'(pair_splits > 0), 64'd1, "pair splits seen");
        check_eq(64'(dual_acks > 0), 64'd1, "dual acks seen");
        $display("%0d uops, %0d stall cycles, %0d pair splits, %0d dual acks",
                 head, stall_cycles, pair_splits, dual_acks);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rvv_dispatch.f
rtl/rvv_dispatch_pkg.sv
rtl/rvv_dispatch_raw_uop_uop.sv
rtl/rvv_dispatch_inflight.sv
rtl/rvv_dispatch_ctrl.sv
rtl/rvv_dispatch.sv
tests/tb_rvv_dispatch.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rvv_dispatch
FILELIST  ?= rvv_dispatch.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the binary is the test verdict
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
